//--- files.f
+incdir+include
src/axi_pkg.sv
src/lsu_pkg.sv
src/lsu_unit.sv
src/fetch_unit.sv
src/axi_arbiter.sv
src/sram_slave.sv
src/mem_subsys_top.sv
verif/tb_mem_subsys.sv

//--- include/mem_map.svh
// SRAM window base address and size macros
`ifndef MEM_MAP_SVH
`define MEM_MAP_SVH

// byte address of the first SRAM word
`define MEM_BASE 32'h8000_0000

// window size in bytes, 4 KiB
`define MEM_BYTES 32'h0000_1000

`endif

//--- run.sh
#!/usr/bin/env bash
# builds and runs the memory subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	-f files.f --top-module tb_mem_subsys -o tb_mem_subsys

./obj_dir/tb_mem_subsys | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

//--- src/axi_arbiter.sv
// round-robin AXI-lite arbiter, two masters onto one slave, grant held per transaction
`timescale 1ns/1ps

module axi_arbiter (
	input  logic            clock,
	input  logic            rstn,
	// master 0, read and write
	input  logic            m0_ar_valid_i,
	input  axi_pkg::ar_t    m0_ar_i,
	output logic            m0_ar_ready_o,
	output logic            m0_r_valid_o,
	output axi_pkg::r_t     m0_r_o,
	input  logic            m0_r_ready_i,
	input  logic            m0_aw_valid_i,
	input  axi_pkg::aw_t    m0_aw_i,
	output logic            m0_aw_ready_o,
	input  logic            m0_w_valid_i,
	input  axi_pkg::w_t     m0_w_i,
	output logic            m0_w_ready_o,
	output logic            m0_b_valid_o,
	output axi_pkg::resp_e  m0_b_resp_o,
	input  logic            m0_b_ready_i,
	// master 1, read only
	input  logic            m1_ar_valid_i,
	input  axi_pkg::ar_t    m1_ar_i,
	output logic            m1_ar_ready_o,
	output logic            m1_r_valid_o,
	output axi_pkg::r_t     m1_r_o,
	input  logic            m1_r_ready_i,
	// toward the slave
	output logic            s_ar_valid_o,
	output axi_pkg::ar_t    s_ar_o,
	input  logic            s_ar_ready_i,
	input  logic            s_r_valid_i,
	input  axi_pkg::r_t     s_r_i,
	output logic            s_r_ready_o,
	output logic            s_aw_valid_o,
	output axi_pkg::aw_t    s_aw_o,
	input  logic            s_aw_ready_i,
	output logic            s_w_valid_o,
	output axi_pkg::w_t     s_w_o,
	input  logic            s_w_ready_i,
	input  logic            s_b_valid_i,
	input  axi_pkg::resp_e  s_b_resp_i,
	output logic            s_b_ready_o
);

	typedef enum logic [1:0] {
		IDLE,
		BUSY_M0,
		BUSY_M1
	} arb_state_e;

	arb_state_e state_q;
	// set when master 1 wins a tie
	logic       prio_q;
	logic       m0_req;
	logic       sel_m1;
	logic       resp_done;

	assign m0_req    = m0_ar_valid_i || m0_aw_valid_i;
	assign resp_done = (s_r_valid_i && s_r_ready_o) || (s_b_valid_i && s_b_ready_o);

	// in IDLE the winner is routed straight away, so no cycle is lost
	always_comb begin
		case (state_q)
			BUSY_M0: sel_m1 = 1'b0;
			BUSY_M1: sel_m1 = 1'b1;
			default: sel_m1 = m1_ar_valid_i && (!m0_req || prio_q);
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q <= IDLE;
			prio_q  <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (m0_req || m1_ar_valid_i) begin
						state_q <= sel_m1 ? BUSY_M1 : BUSY_M0;
					end
				end
				BUSY_M0, BUSY_M1: begin
					if (resp_done) begin
						state_q <= IDLE;
						// the other master gets the next tie
						prio_q  <= (state_q == BUSY_M0);
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// requests to the slave
	assign s_ar_valid_o = sel_m1 ? m1_ar_valid_i : m0_ar_valid_i;
	assign s_ar_o       = sel_m1 ? m1_ar_i : m0_ar_i;
	assign s_r_ready_o  = sel_m1 ? m1_r_ready_i : m0_r_ready_i;
	assign s_aw_valid_o = !sel_m1 && m0_aw_valid_i;
	assign s_aw_o       = m0_aw_i;
	assign s_w_valid_o  = !sel_m1 && m0_w_valid_i;
	assign s_w_o        = m0_w_i;
	assign s_b_ready_o  = !sel_m1 && m0_b_ready_i;

	// readies and responses only reach the winner
	assign m0_ar_ready_o = !sel_m1 && s_ar_ready_i;
	assign m0_r_valid_o  = !sel_m1 && s_r_valid_i;
	assign m0_r_o        = s_r_i;
	assign m0_aw_ready_o = !sel_m1 && s_aw_ready_i;
	assign m0_w_ready_o  = !sel_m1 && s_w_ready_i;
	assign m0_b_valid_o  = !sel_m1 && s_b_valid_i;
	assign m0_b_resp_o   = s_b_resp_i;
	assign m1_ar_ready_o = sel_m1 && s_ar_ready_i;
	assign m1_r_valid_o  = sel_m1 && s_r_valid_i;
	assign m1_r_o        = s_r_i;

endmodule

//--- src/axi_pkg.sv
// AXI-lite channel structs, response codes and access size code
package axi_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [2:0]  size_t;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_e;

	// four bytes per beat
	localparam size_t SIZE_WORD = 3'b010;

	typedef struct packed {
		addr_t addr;
		size_t size;
	} ar_t;

	typedef struct packed {
		addr_t addr;
		size_t size;
	} aw_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_t;

	typedef struct packed {
		data_t data;
		resp_e resp;
	} r_t;

endpackage

//--- src/fetch_unit.sv
// instruction fetch master issuing single word reads
`timescale 1ns/1ps

module fetch_unit (
	input  logic            clock,
	input  logic            rstn,
	input  logic            start_i,
	input  axi_pkg::addr_t  pc_i,
	output logic            done_o,
	output axi_pkg::data_t  instr_o,
	output logic            err_o,
	output logic            ar_valid_o,
	output axi_pkg::ar_t    ar_o,
	input  logic            ar_ready_i,
	input  logic            r_valid_i,
	input  axi_pkg::r_t     r_i,
	output logic            r_ready_o
);

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		RESP
	} fetch_state_e;

	fetch_state_e   state_q;
	logic           done_q;
	axi_pkg::addr_t pc_q;
	axi_pkg::data_t instr_q;
	logic           err_q;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q <= IDLE;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				IDLE: begin
					if (start_i) begin
						state_q <= ADDR;
					end
				end
				ADDR: begin
					if (ar_ready_i) begin
						state_q <= RESP;
					end
				end
				RESP: begin
					if (r_valid_i) begin
						state_q <= IDLE;
						done_q  <= 1'b1;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == IDLE && start_i) begin
			pc_q <= pc_i;
		end
		if (r_valid_i && r_ready_o) begin
			instr_q <= r_i.data;
			err_q   <= (r_i.resp != axi_pkg::OKAY);
		end
	end

	assign ar_valid_o = (state_q == ADDR);
	assign r_ready_o  = (state_q == RESP);

	always_comb begin
		ar_o.addr = {pc_q[31:2], 2'b00};
		ar_o.size = axi_pkg::SIZE_WORD;
	end

	assign done_o  = done_q;
	assign instr_o = instr_q;
	assign err_o   = err_q;

endmodule

//--- src/lsu_pkg.sv
// load/store type enums, register and CSR field types, LSU request and result structs
package lsu_pkg;

	typedef enum logic [2:0] {
		LD_NONE = 3'd0,
		LD_B    = 3'd1,
		LD_H    = 3'd2,
		LD_W    = 3'd3,
		LD_BU   = 3'd4,
		LD_HU   = 3'd5
	} load_e;

	typedef enum logic [1:0] {
		ST_NONE = 2'd0,
		ST_B    = 2'd1,
		ST_H    = 2'd2,
		ST_W    = 2'd3
	} store_e;

	typedef logic [4:0] reg_idx_t;
	typedef logic [2:0] csr_type_t;

	// addr is the ALU result, also the write-back value for non-memory ops
	typedef struct packed {
		axi_pkg::addr_t addr;
		axi_pkg::data_t wdata;
		load_e          load;
		store_e         store;
		logic           wd;
		reg_idx_t       rd;
		axi_pkg::data_t csr_wdata;
		csr_type_t      csr_type;
	} lsu_req_t;

	typedef struct packed {
		axi_pkg::data_t wb_data;
		logic           wd;
		reg_idx_t       rd;
		axi_pkg::data_t csr_wdata;
		csr_type_t      csr_type;
		logic           err;
	} lsu_res_t;

endpackage

//--- src/lsu_unit.sv
// load/store unit: request FSM, store lane alignment, load shift and extension
`timescale 1ns/1ps

module lsu_unit (
	input  logic                clock,
	input  logic                rstn,
	input  logic                start_i,
	input  lsu_pkg::lsu_req_t   req_i,
	output logic                done_o,
	output lsu_pkg::lsu_res_t   res_o,
	output logic                ar_valid_o,
	output axi_pkg::ar_t        ar_o,
	input  logic                ar_ready_i,
	input  logic                r_valid_i,
	input  axi_pkg::r_t         r_i,
	output logic                r_ready_o,
	output logic                aw_valid_o,
	output axi_pkg::aw_t        aw_o,
	input  logic                aw_ready_i,
	output logic                w_valid_o,
	output axi_pkg::w_t         w_o,
	input  logic                w_ready_i,
	input  logic                b_valid_i,
	input  axi_pkg::resp_e      b_resp_i,
	output logic                b_ready_o
);

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		RESP,
		DONE
	} lsu_state_e;

	lsu_state_e        state_q;
	lsu_pkg::lsu_req_t req_q;
	axi_pkg::data_t    rdata_q;
	logic              err_q;

	logic              is_load;
	logic              is_store;
	logic [1:0]        lane;
	axi_pkg::addr_t    word_addr;
	axi_pkg::strb_t    base_strb;
	axi_pkg::data_t    rdata_shift;
	axi_pkg::data_t    load_data;

	// a request carrying both types is treated as a load
	assign is_load   = (req_q.load != lsu_pkg::LD_NONE);
	assign is_store  = (req_q.store != lsu_pkg::ST_NONE) && !is_load;
	assign lane      = req_q.addr[1:0];
	assign word_addr = {req_q.addr[31:2], 2'b00};

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE: begin
					if (start_i) begin
						state_q <= ADDR;
					end
				end
				ADDR: begin
					if (!is_load && !is_store) begin
						state_q <= DONE;
					end else if (ar_valid_o && ar_ready_i) begin
						state_q <= RESP;
					end else if (aw_valid_o && aw_ready_i && w_valid_o && w_ready_i) begin
						// AW and W must go in the same cycle
						state_q <= RESP;
					end
				end
				RESP: begin
					if ((r_valid_i && r_ready_o) || (b_valid_i && b_ready_o)) begin
						state_q <= DONE;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// request and response payload
	always_ff @(posedge clock) begin
		if (state_q == IDLE && start_i) begin
			req_q <= req_i;
			err_q <= 1'b0;
		end
		if (r_valid_i && r_ready_o) begin
			rdata_q <= r_i.data;
			err_q   <= (r_i.resp != axi_pkg::OKAY);
		end
		if (b_valid_i && b_ready_o) begin
			err_q <= (b_resp_i != axi_pkg::OKAY);
		end
	end

	assign ar_valid_o = (state_q == ADDR) && is_load;
	assign aw_valid_o = (state_q == ADDR) && is_store;
	assign w_valid_o  = (state_q == ADDR) && is_store;
	assign r_ready_o  = (state_q == RESP) && is_load;
	assign b_ready_o  = (state_q == RESP) && is_store;

	always_comb begin
		case (req_q.store)
			lsu_pkg::ST_B: base_strb = 4'b0001;
			lsu_pkg::ST_H: base_strb = 4'b0011;
			lsu_pkg::ST_W: base_strb = 4'b1111;
			default:       base_strb = 4'b0000;
		endcase
	end

	always_comb begin
		ar_o.addr = word_addr;
		ar_o.size = axi_pkg::SIZE_WORD;
		aw_o.addr = word_addr;
		aw_o.size = axi_pkg::SIZE_WORD;
		// move the low bytes up into the addressed lane
		w_o.data  = req_q.wdata << {lane, 3'b000};
		w_o.strb  = base_strb << lane;
	end

	// bring the addressed lane down to bit 0, then extend
	assign rdata_shift = rdata_q >> {lane, 3'b000};

	always_comb begin
		case (req_q.load)
			lsu_pkg::LD_B:  load_data = {{24{rdata_shift[7]}}, rdata_shift[7:0]};
			lsu_pkg::LD_H:  load_data = {{16{rdata_shift[15]}}, rdata_shift[15:0]};
			lsu_pkg::LD_BU: load_data = {24'b0, rdata_shift[7:0]};
			lsu_pkg::LD_HU: load_data = {16'b0, rdata_shift[15:0]};
			default:        load_data = rdata_shift;
		endcase
	end

	assign done_o = (state_q == DONE);

	always_comb begin
		res_o.wb_data   = is_load ? load_data : req_q.addr;
		res_o.wd        = req_q.wd;
		res_o.rd        = req_q.rd;
		res_o.csr_wdata = req_q.csr_wdata;
		res_o.csr_type  = req_q.csr_type;
		res_o.err       = err_q;
	end

endmodule

//--- src/mem_subsys_top.sv
// memory subsystem top: LSU and fetch masters, arbiter and SRAM slave
`timescale 1ns/1ps

`include "mem_map.svh"

module mem_subsys_top (
	input  logic               clock,
	input  logic               rstn,
	input  logic               lsu_start_i,
	input  lsu_pkg::lsu_req_t  lsu_req_i,
	output logic               lsu_done_o,
	output lsu_pkg::lsu_res_t  lsu_res_o,
	input  logic               fetch_start_i,
	input  axi_pkg::addr_t     fetch_pc_i,
	output logic               fetch_done_o,
	output axi_pkg::data_t     fetch_instr_o,
	output logic               fetch_err_o
);

	localparam int MEM_WORDS = `MEM_BYTES / 4;

	// LSU side, master 0
	logic           m0_ar_valid;
	axi_pkg::ar_t   m0_ar;
	logic           m0_ar_ready;
	logic           m0_r_valid;
	axi_pkg::r_t    m0_r;
	logic           m0_r_ready;
	logic           m0_aw_valid;
	axi_pkg::aw_t   m0_aw;
	logic           m0_aw_ready;
	logic           m0_w_valid;
	axi_pkg::w_t    m0_w;
	logic           m0_w_ready;
	logic           m0_b_valid;
	axi_pkg::resp_e m0_b_resp;
	logic           m0_b_ready;

	// fetch side, master 1
	logic           m1_ar_valid;
	axi_pkg::ar_t   m1_ar;
	logic           m1_ar_ready;
	logic           m1_r_valid;
	axi_pkg::r_t    m1_r;
	logic           m1_r_ready;

	// arbiter to SRAM
	logic           s_ar_valid;
	axi_pkg::ar_t   s_ar;
	logic           s_ar_ready;
	logic           s_r_valid;
	axi_pkg::r_t    s_r;
	logic           s_r_ready;
	logic           s_aw_valid;
	axi_pkg::aw_t   s_aw;
	logic           s_aw_ready;
	logic           s_w_valid;
	axi_pkg::w_t    s_w;
	logic           s_w_ready;
	logic           s_b_valid;
	axi_pkg::resp_e s_b_resp;
	logic           s_b_ready;

	lsu_unit i_lsu_unit (
		.clock      (clock),
		.rstn       (rstn),
		.start_i    (lsu_start_i),
		.req_i      (lsu_req_i),
		.done_o     (lsu_done_o),
		.res_o      (lsu_res_o),
		.ar_valid_o (m0_ar_valid),
		.ar_o       (m0_ar),
		.ar_ready_i (m0_ar_ready),
		.r_valid_i  (m0_r_valid),
		.r_i        (m0_r),
		.r_ready_o  (m0_r_ready),
		.aw_valid_o (m0_aw_valid),
		.aw_o       (m0_aw),
		.aw_ready_i (m0_aw_ready),
		.w_valid_o  (m0_w_valid),
		.w_o        (m0_w),
		.w_ready_i  (m0_w_ready),
		.b_valid_i  (m0_b_valid),
		.b_resp_i   (m0_b_resp),
		.b_ready_o  (m0_b_ready)
	);

	fetch_unit i_fetch_unit (
		.clock      (clock),
		.rstn       (rstn),
		.start_i    (fetch_start_i),
		.pc_i       (fetch_pc_i),
		.done_o     (fetch_done_o),
		.instr_o    (fetch_instr_o),
		.err_o      (fetch_err_o),
		.ar_valid_o (m1_ar_valid),
		.ar_o       (m1_ar),
		.ar_ready_i (m1_ar_ready),
		.r_valid_i  (m1_r_valid),
		.r_i        (m1_r),
		.r_ready_o  (m1_r_ready)
	);

	axi_arbiter i_axi_arbiter (
		.clock         (clock),
		.rstn          (rstn),
		.m0_ar_valid_i (m0_ar_valid),
		.m0_ar_i       (m0_ar),
		.m0_ar_ready_o (m0_ar_ready),
		.m0_r_valid_o  (m0_r_valid),
		.m0_r_o        (m0_r),
		.m0_r_ready_i  (m0_r_ready),
		.m0_aw_valid_i (m0_aw_valid),
		.m0_aw_i       (m0_aw),
		.m0_aw_ready_o (m0_aw_ready),
		.m0_w_valid_i  (m0_w_valid),
		.m0_w_i        (m0_w),
		.m0_w_ready_o  (m0_w_ready),
		.m0_b_valid_o  (m0_b_valid),
		.m0_b_resp_o   (m0_b_resp),
		.m0_b_ready_i  (m0_b_ready),
		.m1_ar_valid_i (m1_ar_valid),
		.m1_ar_i       (m1_ar),
		.m1_ar_ready_o (m1_ar_ready),
		.m1_r_valid_o  (m1_r_valid),
		.m1_r_o        (m1_r),
		.m1_r_ready_i  (m1_r_ready),
		.s_ar_valid_o  (s_ar_valid),
		.s_ar_o        (s_ar),
		.s_ar_ready_i  (s_ar_ready),
		.s_r_valid_i   (s_r_valid),
		.s_r_i         (s_r),
		.s_r_ready_o   (s_r_ready),
		.s_aw_valid_o  (s_aw_valid),
		.s_aw_o        (s_aw),
		.s_aw_ready_i  (s_aw_ready),
		.s_w_valid_o   (s_w_valid),
		.s_w_o         (s_w),
		.s_w_ready_i   (s_w_ready),
		.s_b_valid_i   (s_b_valid),
		.s_b_resp_i    (s_b_resp),
		.s_b_ready_o   (s_b_ready)
	);

	sram_slave #(
		.MEM_WORDS (MEM_WORDS)
	) i_sram_slave (
		.clock      (clock),
		.rstn       (rstn),
		.ar_valid_i (s_ar_valid),
		.ar_i       (s_ar),
		.ar_ready_o (s_ar_ready),
		.r_valid_o  (s_r_valid),
		.r_o        (s_r),
		.r_ready_i  (s_r_ready),
		.aw_valid_i (s_aw_valid),
		.aw_i       (s_aw),
		.aw_ready_o (s_aw_ready),
		.w_valid_i  (s_w_valid),
		.w_i        (s_w),
		.w_ready_o  (s_w_ready),
		.b_valid_o  (s_b_valid),
		.b_resp_o   (s_b_resp),
		.b_ready_i  (s_b_ready)
	);

endmodule

//--- src/sram_slave.sv
// word SRAM behind an AXI-lite slave with byte strobes and window decode
`timescale 1ns/1ps

`include "mem_map.svh"

module sram_slave #(
	parameter int MEM_WORDS = 1024
) (
	input  logic            clock,
	input  logic            rstn,
	input  logic            ar_valid_i,
	input  axi_pkg::ar_t    ar_i,
	output logic            ar_ready_o,
	output logic            r_valid_o,
	output axi_pkg::r_t     r_o,
	input  logic            r_ready_i,
	input  logic            aw_valid_i,
	input  axi_pkg::aw_t    aw_i,
	output logic            aw_ready_o,
	input  logic            w_valid_i,
	input  axi_pkg::w_t     w_i,
	output logic            w_ready_o,
	output logic            b_valid_o,
	output axi_pkg::resp_e  b_resp_o,
	input  logic            b_ready_i
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam axi_pkg::addr_t BASE = `MEM_BASE;

	axi_pkg::data_t mem [MEM_WORDS];

	logic           r_valid_q;
	logic           b_valid_q;
	axi_pkg::r_t    r_q;
	axi_pkg::resp_e b_resp_q;
	logic           idle;
	logic           rd_go;
	logic           wr_go;
	axi_pkg::addr_t rd_off;
	axi_pkg::addr_t wr_off;
	logic           rd_hit;
	logic           wr_hit;

	assign idle = !r_valid_q && !b_valid_q;

	// reads win if both arrive together
	assign ar_ready_o = idle;
	assign aw_ready_o = idle && !ar_valid_i && w_valid_i;
	assign w_ready_o  = idle && !ar_valid_i && aw_valid_i;

	assign rd_go = ar_valid_i && ar_ready_o;
	assign wr_go = aw_valid_i && aw_ready_o && w_valid_i && w_ready_o;

	// window decode on byte offsets from the base
	assign rd_off = ar_i.addr - BASE;
	assign wr_off = aw_i.addr - BASE;
	assign rd_hit = (ar_i.addr >= BASE) && (rd_off < `MEM_BYTES);
	assign wr_hit = (aw_i.addr >= BASE) && (wr_off < `MEM_BYTES);

	always_ff @(posedge clock) begin
		if (!rstn) begin
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			if (rd_go) begin
				r_valid_q <= 1'b1;
			end else if (r_ready_i) begin
				r_valid_q <= 1'b0;
			end
			if (wr_go) begin
				b_valid_q <= 1'b1;
			end else if (b_ready_i) begin
				b_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rd_go) begin
			r_q.data <= rd_hit ? mem[rd_off[IDX_W+1:2]] : '0;
			r_q.resp <= rd_hit ? axi_pkg::OKAY : axi_pkg::SLVERR;
		end
		if (wr_go) begin
			b_resp_q <= wr_hit ? axi_pkg::OKAY : axi_pkg::SLVERR;
			if (wr_hit) begin
				for (int i = 0; i < 4; i++) begin
					if (w_i.strb[i]) begin
						mem[wr_off[IDX_W+1:2]][i*8 +: 8] <= w_i.data[i*8 +: 8];
					end
				end
			end
		end
	end

	assign r_valid_o = r_valid_q;
	assign r_o       = r_q;
	assign b_valid_o = b_valid_q;
	assign b_resp_o  = b_resp_q;

endmodule

//--- verif/tb_mem_subsys.sv
// testbench for mem_subsys_top with LFSR stimulus, reference model and result checker
`timescale 1ns/1ps

`include "mem_map.svh"

module tb_mem_subsys;

	localparam int TIMEOUT = 60;
	// test region of 16 words inside the SRAM window
	localparam logic [31:0] REGION_BASE = `MEM_BASE + 32'h40;

	logic              clock = 1'b0;
	logic              rstn;
	logic              lsu_start;
	lsu_pkg::lsu_req_t lsu_req;
	logic              lsu_done;
	lsu_pkg::lsu_res_t lsu_res;
	logic              fetch_start;
	logic [31:0]       fetch_pc;
	logic              fetch_done;
	logic [31:0]       fetch_instr;
	logic              fetch_err;

	logic [15:0]       lfsr_q = 16'd60217;
	logic [31:0]       model [16];
	lsu_pkg::lsu_res_t exp_lsu_q [$];
	logic [32:0]       exp_fetch_q [$];
	int                errors = 0;
	int                checks = 0;

	mem_subsys_top i_mem_subsys_top (
		.clock         (clock),
		.rstn          (rstn),
		.lsu_start_i   (lsu_start),
		.lsu_req_i     (lsu_req),
		.lsu_done_o    (lsu_done),
		.lsu_res_o     (lsu_res),
		.fetch_start_i (fetch_start),
		.fetch_pc_i    (fetch_pc),
		.fetch_done_o  (fetch_done),
		.fetch_instr_o (fetch_instr),
		.fetch_err_o   (fetch_err)
	);

	always #20 clock = ~clock;

	// taps of x^16 + x^14 + x^13 + x^11, stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic logic in_window(input logic [31:0] addr);
		return (addr >= `MEM_BASE) && ((addr - `MEM_BASE) < `MEM_BYTES);
	endfunction

	function automatic logic [3:0] model_index(input logic [31:0] addr);
		logic [31:0] off;
		off = addr - REGION_BASE;
		return off[5:2];
	endfunction

	function automatic logic [31:0] region_addr(input logic [3:0] idx);
		return REGION_BASE + {26'b0, idx, 2'b00};
	endfunction

	// pick the addressed bytes, then sign or zero fill the rest
	function automatic logic [31:0] ref_load(input logic [31:0] word, input logic [1:0] lane,
			input lsu_pkg::load_e ld);
		int          nbytes;
		int          l;
		logic        sign_ext;
		logic [31:0] v;
		l = int'(lane);
		nbytes = 4;
		sign_ext = 1'b0;
		case (ld)
			lsu_pkg::LD_B: begin
				nbytes = 1;
				sign_ext = 1'b1;
			end
			lsu_pkg::LD_BU: nbytes = 1;
			lsu_pkg::LD_H: begin
				nbytes = 2;
				sign_ext = 1'b1;
			end
			lsu_pkg::LD_HU: nbytes = 2;
			default: nbytes = 4;
		endcase
		v = '0;
		for (int b = 0; b < nbytes; b++) begin
			if (l + b < 4) begin
				v[b*8 +: 8] = word[(l+b)*8 +: 8];
			end
		end
		if (sign_ext && v[nbytes*8-1]) begin
			for (int b = nbytes; b < 4; b++) begin
				v[b*8 +: 8] = 8'hff;
			end
		end
		return v;
	endfunction

	// merge the low store bytes into the word starting at the lane
	function automatic logic [31:0] ref_store(input logic [31:0] old, input logic [31:0] data,
			input logic [1:0] lane, input lsu_pkg::store_e st);
		int          nbytes;
		int          l;
		logic [31:0] v;
		l = int'(lane);
		case (st)
			lsu_pkg::ST_B: nbytes = 1;
			lsu_pkg::ST_H: nbytes = 2;
			lsu_pkg::ST_W: nbytes = 4;
			default: nbytes = 0;
		endcase
		v = old;
		for (int b = 0; b < nbytes; b++) begin
			if (l + b < 4) begin
				v[(l+b)*8 +: 8] = data[b*8 +: 8];
			end
		end
		return v;
	endfunction

	function automatic lsu_pkg::lsu_res_t ref_lsu_result(input lsu_pkg::lsu_req_t req);
		lsu_pkg::lsu_res_t res;
		logic              mem_op;
		logic [31:0]       word;
		mem_op = (req.load != lsu_pkg::LD_NONE) || (req.store != lsu_pkg::ST_NONE);
		word = in_window(req.addr) ? model[model_index(req.addr)] : 32'h0;
		res.wd = req.wd;
		res.rd = req.rd;
		res.csr_wdata = req.csr_wdata;
		res.csr_type = req.csr_type;
		res.err = mem_op && !in_window(req.addr);
		if (req.load != lsu_pkg::LD_NONE) begin
			res.wb_data = ref_load(word, req.addr[1:0], req.load);
		end else begin
			res.wb_data = req.addr;
		end
		return res;
	endfunction

	// {err, instr}
	function automatic logic [32:0] ref_fetch_result(input logic [31:0] pc);
		if (in_window(pc)) begin
			return {1'b0, model[model_index(pc)]};
		end
		return {1'b1, 32'h0};
	endfunction

	function automatic lsu_pkg::lsu_req_t make_req(input logic [31:0] addr,
			input logic [31:0] wdata, input lsu_pkg::load_e ld, input lsu_pkg::store_e st);
		lsu_pkg::lsu_req_t req;
		logic [31:0]       r;
		r = rand_bits(9);
		req.addr = addr;
		req.wdata = wdata;
		req.load = ld;
		req.store = st;
		req.wd = r[0];
		req.rd = r[5:1];
		req.csr_type = r[8:6];
		req.csr_wdata = rand_bits(32);
		return req;
	endfunction

	// combos 0..3 byte lanes, 4..5 halfword lanes, 6 word
	function automatic lsu_pkg::lsu_req_t store_req(input logic [3:0] idx, input int combo);
		lsu_pkg::store_e st;
		logic [1:0]      lane;
		st = (combo < 4) ? lsu_pkg::ST_B : ((combo < 6) ? lsu_pkg::ST_H : lsu_pkg::ST_W);
		lane = (combo < 4) ? 2'(combo) : ((combo == 5) ? 2'd2 : 2'd0);
		return make_req(region_addr(idx) + {30'b0, lane}, rand_bits(32), lsu_pkg::LD_NONE, st);
	endfunction

	// combos 0..3 LB, 4..7 LBU, 8..9 LH, 10..11 LHU, 12 LW
	function automatic lsu_pkg::lsu_req_t load_req(input logic [3:0] idx, input int combo);
		lsu_pkg::load_e ld;
		logic [1:0]     lane;
		case (combo)
			0, 1, 2, 3: ld = lsu_pkg::LD_B;
			4, 5, 6, 7: ld = lsu_pkg::LD_BU;
			8, 9: ld = lsu_pkg::LD_H;
			10, 11: ld = lsu_pkg::LD_HU;
			default: ld = lsu_pkg::LD_W;
		endcase
		if (combo < 8) begin
			lane = 2'(combo % 4);
		end else if (combo < 12) begin
			lane = (combo % 2 == 1) ? 2'd2 : 2'd0;
		end else begin
			lane = 2'd0;
		end
		return make_req(region_addr(idx) + {30'b0, lane}, rand_bits(32), ld, lsu_pkg::ST_NONE);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
		errors++;
	endtask

	// start one or both units on the same falling edge, then wait for their done pulses
	task automatic launch(input logic do_lsu, input lsu_pkg::lsu_req_t req,
			input logic do_fetch, input logic [31:0] pc);
		int         n;
		logic       seen_l;
		logic       seen_f;
		logic [3:0] idx;
		@(negedge clock);
		if (do_lsu) begin
			exp_lsu_q.push_back(ref_lsu_result(req));
			if (req.load == lsu_pkg::LD_NONE && req.store != lsu_pkg::ST_NONE
					&& in_window(req.addr)) begin
				idx = model_index(req.addr);
				model[idx] = ref_store(model[idx], req.wdata, req.addr[1:0], req.store);
			end
			lsu_req = req;
			lsu_start = 1'b1;
		end
		if (do_fetch) begin
			exp_fetch_q.push_back(ref_fetch_result(pc));
			fetch_pc = pc;
			fetch_start = 1'b1;
		end
		@(negedge clock);
		lsu_start = 1'b0;
		fetch_start = 1'b0;
		seen_l = !do_lsu;
		seen_f = !do_fetch;
		n = 0;
		while (n < TIMEOUT) begin
			if (lsu_done) seen_l = 1'b1;
			if (fetch_done) seen_f = 1'b1;
			if (seen_l && seen_f) break;
			@(negedge clock);
			n++;
		end
		if (!(seen_l && seen_f)) begin
			$display("timeout: no done pulse within %0d cycles (lsu %0b, fetch %0b)",
				TIMEOUT, seen_l, seen_f);
			errors++;
		end
	endtask

	task automatic check_lsu;
		lsu_pkg::lsu_res_t e;
		if (exp_lsu_q.size() == 0) begin
			$display("LSU done pulse arrived with no request outstanding");
			errors++;
		end else begin
			e = exp_lsu_q.pop_front();
			checks++;
			if (lsu_res.wb_data !== e.wb_data)
				report_mismatch("lsu_res_o.wb_data", lsu_res.wb_data, e.wb_data);
			if (lsu_res.wd !== e.wd)
				report_mismatch("lsu_res_o.wd", 32'(lsu_res.wd), 32'(e.wd));
			if (lsu_res.rd !== e.rd)
				report_mismatch("lsu_res_o.rd", 32'(lsu_res.rd), 32'(e.rd));
			if (lsu_res.csr_wdata !== e.csr_wdata)
				report_mismatch("lsu_res_o.csr_wdata", lsu_res.csr_wdata, e.csr_wdata);
			if (lsu_res.csr_type !== e.csr_type)
				report_mismatch("lsu_res_o.csr_type", 32'(lsu_res.csr_type), 32'(e.csr_type));
			if (lsu_res.err !== e.err)
				report_mismatch("lsu_res_o.err", 32'(lsu_res.err), 32'(e.err));
		end
	endtask

	task automatic check_fetch;
		logic [32:0] e;
		if (exp_fetch_q.size() == 0) begin
			$display("fetch done pulse arrived with no fetch outstanding");
			errors++;
		end else begin
			e = exp_fetch_q.pop_front();
			checks++;
			if (fetch_instr !== e[31:0])
				report_mismatch("fetch_instr_o", fetch_instr, e[31:0]);
			if (fetch_err !== e[32])
				report_mismatch("fetch_err_o", 32'(fetch_err), 32'(e[32]));
		end
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clock) begin
		if (rstn) begin
			if (lsu_done) check_lsu();
			if (fetch_done) check_fetch();
		end
	end

	initial begin
		logic [31:0] r;
		logic [3:0]  widx;
		logic [3:0]  fidx;
		rstn = 1'b0;
		lsu_start = 1'b0;
		lsu_req = '0;
		fetch_start = 1'b0;
		fetch_pc = '0;
		repeat (5) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		if (lsu_done || fetch_done) begin
			$display("a done pulse is high right after reset");
			errors++;
		end

		// SRAM is not reset, so fill the test region first
		for (int i = 0; i < 16; i++)
			launch(1'b1, store_req(4'(i), 6), 1'b0, '0);

		// non-memory requests
		for (int i = 0; i < 8; i++)
			launch(1'b1, make_req(rand_bits(32), rand_bits(32), lsu_pkg::LD_NONE,
				lsu_pkg::ST_NONE), 1'b0, '0);

		// every store size and lane, each read back with LW
		for (int round = 0; round < 3; round++) begin
			for (int c = 0; c < 7; c++) begin
				r = rand_bits(4);
				widx = r[3:0];
				launch(1'b1, store_req(widx, c), 1'b0, '0);
				launch(1'b1, load_req(widx, 12), 1'b0, '0);
			end
		end

		// every load type at its legal lanes
		for (int round = 0; round < 2; round++) begin
			for (int c = 0; c < 13; c++) begin
				r = rand_bits(4);
				launch(1'b1, load_req(r[3:0], c), 1'b0, '0);
			end
		end

		// fetches with random low pc bits
		for (int i = 0; i < 16; i++) begin
			r = rand_bits(2);
			launch(1'b0, '0, 1'b1, region_addr(4'(i)) + {30'b0, r[1:0]});
		end

		// both units started together with the fetch kept off the LSU's word
		for (int i = 0; i < 40; i++) begin
			r = rand_bits(13);
			widx = r[3:0];
			fidx = widx + 4'd1 + 4'(int'(r[7:4]) % 15);
			// a lone LSU access first hands the next tie to the fetch unit
			if (r[12]) begin
				launch(1'b1, load_req(widx, 12), 1'b0, '0);
			end
			if (r[9:8] == 2'd0) begin
				launch(1'b1, make_req(rand_bits(32), rand_bits(32), lsu_pkg::LD_NONE,
					lsu_pkg::ST_NONE), 1'b1, region_addr(fidx));
			end else if (r[9:8] == 2'd1) begin
				launch(1'b1, store_req(widx, int'(r[11:10]) + 3), 1'b1, region_addr(fidx));
			end else begin
				launch(1'b1, load_req(widx, int'(r[11:10]) * 4), 1'b1, region_addr(fidx));
			end
		end

		// outside the window at offsets that alias region words 0 and 1
		launch(1'b1, make_req(`MEM_BASE + `MEM_BYTES + 32'h40, 32'hdead_beef,
			lsu_pkg::LD_NONE, lsu_pkg::ST_W), 1'b0, '0);
		launch(1'b1, make_req(`MEM_BASE - 32'h1000 + 32'h44, 32'hcafe_f00d,
			lsu_pkg::LD_NONE, lsu_pkg::ST_B), 1'b0, '0);
		launch(1'b1, make_req(`MEM_BASE + `MEM_BYTES + 32'h40, 32'h0,
			lsu_pkg::LD_W, lsu_pkg::ST_NONE), 1'b0, '0);
		launch(1'b0, '0, 1'b1, `MEM_BASE + `MEM_BYTES + 32'h44);
		for (int i = 0; i < 16; i++) begin
			launch(1'b1, load_req(4'(i), 12), 1'b0, '0);
			launch(1'b0, '0, 1'b1, region_addr(4'(i)));
		end

		repeat (2) @(negedge clock);
		if (exp_lsu_q.size() != 0 || exp_fetch_q.size() != 0) begin
			$display("%0d LSU and %0d fetch results never arrived",
				exp_lsu_q.size(), exp_fetch_q.size());
			errors++;
		end
		$display("results checked %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
